// ==== common/rv32m_pkg.sv ====
package rv32m_pkg;

  localparam int XLEN = 32;

  // one iteration per operand bit
  localparam int MULDIV_STEPS = XLEN;

  // counter must reach MULDIV_STEPS, so one extra bit
  localparam int STEP_CNT_W = $clog2(MULDIV_STEPS + 1);

  // funct3 of the M extension, bit 2 picks the divider
  typedef enum logic [2:0] {
    MUL    = 3'd0,
    MULH   = 3'd1,
    MULHSU = 3'd2,
    MULHU  = 3'd3,
    DIV    = 3'd4,
    DIVU   = 3'd5,
    REM    = 3'd6,
    REMU   = 3'd7
  } muldiv_op_e;

  typedef struct packed {
    muldiv_op_e      op;
    logic [XLEN-1:0] rs1;
    logic [XLEN-1:0] rs2;
  } muldiv_req_t;

endpackage

// ==== design/rv32m_unit.sv ====
`timescale 1ns/100ps

module rv32m_unit import rv32m_pkg::*; (
  input  logic            clk_i,
  input  logic            rst_n_i,
  input  muldiv_req_t     req_i,
  input  logic            start_i,
  input  logic            ack_i,
  input  logic            flush_i,
  output logic [XLEN-1:0] result_o,
  output logic            done_o,
  output logic            busy_o
);

  logic              mul_start;
  logic [XLEN-1:0]   mul_a;
  logic [XLEN-1:0]   mul_b;
  logic [2*XLEN-1:0] mul_product;
  logic              mul_valid;
  logic              div_start;
  logic [XLEN-1:0]   div_a;
  logic [XLEN-1:0]   div_b;
  logic [XLEN-1:0]   div_quot;
  logic [XLEN-1:0]   div_rem;
  logic              div_zero;
  logic              div_valid;

  muldiv_ctrl u_ctrl (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .flush_i       (flush_i),
    .req_i         (req_i),
    .start_i       (start_i),
    .ack_i         (ack_i),
    .result_o      (result_o),
    .done_o        (done_o),
    .busy_o        (busy_o),
    .mul_start_o   (mul_start),
    .mul_a_o       (mul_a),
    .mul_b_o       (mul_b),
    .mul_product_i (mul_product),
    .mul_valid_i   (mul_valid),
    .div_start_o   (div_start),
    .div_a_o       (div_a),
    .div_b_o       (div_b),
    .div_quot_i    (div_quot),
    .div_rem_i     (div_rem),
    .div_zero_i    (div_zero),
    .div_valid_i   (div_valid)
  );

  // flush doubles as the units' clear
  seq_mul u_mul (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .clear_i   (flush_i),
    .start_i   (mul_start),
    .op_a_i    (mul_a),
    .op_b_i    (mul_b),
    .product_o (mul_product),
    .valid_o   (mul_valid)
  );

  seq_div u_div (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .clear_i     (flush_i),
    .start_i     (div_start),
    .dividend_i  (div_a),
    .divisor_i   (div_b),
    .quotient_o  (div_quot),
    .remainder_o (div_rem),
    .div_zero_o  (div_zero),
    .valid_o     (div_valid)
  );

endmodule

// ==== muldiv/muldiv_ctrl.sv ====
`timescale 1ns/100ps

module muldiv_ctrl import rv32m_pkg::*; (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  logic              flush_i,

  input  muldiv_req_t       req_i,
  input  logic              start_i,
  input  logic              ack_i,
  output logic [XLEN-1:0]   result_o,
  output logic              done_o,
  output logic              busy_o,

  output logic              mul_start_o,
  output logic [XLEN-1:0]   mul_a_o,
  output logic [XLEN-1:0]   mul_b_o,
  input  logic [2*XLEN-1:0] mul_product_i,
  input  logic              mul_valid_i,

  output logic              div_start_o,
  output logic [XLEN-1:0]   div_a_o,
  output logic [XLEN-1:0]   div_b_o,
  input  logic [XLEN-1:0]   div_quot_i,
  input  logic [XLEN-1:0]   div_rem_i,
  input  logic              div_zero_i,
  input  logic              div_valid_i
);

  typedef enum logic [1:0] {
    IDLE,
    LAUNCH,
    WAIT
  } ctrl_state_e;

  ctrl_state_e       state;
  muldiv_req_t       req_q;
  logic              accept;
  logic              use_div;
  logic              unit_valid;
  logic              rs1_neg;
  logic              rs2_neg;
  logic [XLEN-1:0]   abs_rs1;
  logic [XLEN-1:0]   abs_rs2;
  logic [XLEN-1:0]   mag_a;
  logic [XLEN-1:0]   mag_b;
  logic              neg_res;
  logic [2*XLEN-1:0] prod_signed;
  logic [XLEN-1:0]   quot_signed;
  logic [XLEN-1:0]   rem_signed;
  logic [XLEN-1:0]   res_sel;

  assign accept     = (state == IDLE) && start_i;
  assign use_div    = req_q.op[2];
  assign unit_valid = use_div ? div_valid_i : mul_valid_i;

  assign rs1_neg = req_q.rs1[XLEN-1];
  assign rs2_neg = req_q.rs2[XLEN-1];
  assign abs_rs1 = rs1_neg ? -req_q.rs1 : req_q.rs1;
  assign abs_rs2 = rs2_neg ? -req_q.rs2 : req_q.rs2;

  // units only see magnitudes and the sign is put back afterwards
  always_comb begin
    case (req_q.op)
      MUL, MULH, DIV: begin
        mag_a   = abs_rs1;
        mag_b   = abs_rs2;
        neg_res = rs1_neg ^ rs2_neg;
      end
      MULHSU: begin
        mag_a   = abs_rs1;
        mag_b   = req_q.rs2;
        neg_res = rs1_neg;
      end
      REM: begin
        mag_a   = abs_rs1;
        mag_b   = abs_rs2;
        neg_res = rs1_neg;   // remainder follows the dividend
      end
      MULHU, DIVU, REMU: begin
        mag_a   = req_q.rs1;
        mag_b   = req_q.rs2;
        neg_res = 1'b0;
      end
    endcase
  end

  assign prod_signed = neg_res ? -mul_product_i : mul_product_i;
  assign quot_signed = neg_res ? -div_quot_i : div_quot_i;
  assign rem_signed  = neg_res ? -div_rem_i : div_rem_i;

  // most-negative / -1 needs no special path
  // |q| of 2^31 with a positive sign wraps back to most-negative and rem is 0
  always_comb begin
    case (req_q.op)
      MUL:                 res_sel = prod_signed[XLEN-1:0];
      MULH, MULHSU, MULHU: res_sel = prod_signed[2*XLEN-1:XLEN];
      DIV, DIVU:           res_sel = div_zero_i ? '1 : quot_signed;
      REM, REMU:           res_sel = div_zero_i ? req_q.rs1 : rem_signed;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i || flush_i) begin
      state  <= IDLE;
      busy_o <= 1'b0;
      done_o <= 1'b0;
    end else begin
      case (state)
        IDLE: begin
          if (start_i) begin
            state  <= LAUNCH;
            busy_o <= 1'b1;
            done_o <= 1'b0;   // new request drops the old result
          end else if (ack_i) begin
            done_o <= 1'b0;
          end
        end
        LAUNCH: state <= WAIT;
        WAIT: begin
          if (unit_valid) begin
            state  <= IDLE;
            busy_o <= 1'b0;
            done_o <= 1'b1;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      req_q <= req_i;
    end
    if ((state == WAIT) && unit_valid && rst_n_i && !flush_i) begin
      result_o <= res_sel;
    end
  end

  // start strobes last exactly the one LAUNCH cycle
  assign mul_start_o = (state == LAUNCH) && !use_div;
  assign div_start_o = (state == LAUNCH) && use_div;
  assign mul_a_o     = mag_a;
  assign mul_b_o     = mag_b;
  assign div_a_o     = mag_a;
  assign div_b_o     = mag_b;

endmodule

// ==== muldiv/seq_div.sv ====
`timescale 1ns/100ps

module seq_div import rv32m_pkg::*; (
  input  logic            clk_i,
  input  logic            rst_n_i,
  input  logic            clear_i,
  input  logic            start_i,
  input  logic [XLEN-1:0] dividend_i,
  input  logic [XLEN-1:0] divisor_i,
  output logic [XLEN-1:0] quotient_o,
  output logic [XLEN-1:0] remainder_o,
  output logic            div_zero_o,
  output logic            valid_o
);

  logic                  running;
  logic [STEP_CNT_W-1:0] step_cnt;
  logic                  last_step;
  logic                  load;
  logic                  step;
  logic [XLEN-1:0]       rem_q;
  logic [XLEN-1:0]       quot_q;   // dividend bits shift out, quotient bits shift in
  logic [XLEN-1:0]       divisor_q;
  logic [XLEN:0]         partial;
  logic                  fits;

  assign last_step = (step_cnt == STEP_CNT_W'(MULDIV_STEPS));
  assign load      = start_i && !running;
  assign step      = running && !last_step;

  // bring down the next dividend bit and trial-subtract
  assign partial = {rem_q, quot_q[XLEN-1]};
  assign fits    = (partial >= {1'b0, divisor_q});

  always_ff @(posedge clk_i) begin
    if (!rst_n_i || clear_i) begin
      running    <= 1'b0;
      step_cnt   <= '0;
      valid_o    <= 1'b0;
      div_zero_o <= 1'b0;
    end else begin
      valid_o <= 1'b0;
      if (load) begin
        running    <= 1'b1;
        step_cnt   <= '0;
        div_zero_o <= (divisor_i == '0);
      end else if (running) begin
        if (last_step) begin
          running <= 1'b0;
          valid_o <= 1'b1;
        end else begin
          step_cnt <= step_cnt + 1'b1;
        end
      end
    end
  end

  // a zero divisor always fits, so this ends with all-ones and the dividend
  always_ff @(posedge clk_i) begin
    if (load) begin
      rem_q     <= '0;
      quot_q    <= dividend_i;
      divisor_q <= divisor_i;
    end else if (step) begin
      if (fits) begin
        rem_q  <= XLEN'(partial - {1'b0, divisor_q});
        quot_q <= {quot_q[XLEN-2:0], 1'b1};
      end else begin
        rem_q  <= partial[XLEN-1:0];
        quot_q <= {quot_q[XLEN-2:0], 1'b0};
      end
    end
  end

  assign quotient_o  = quot_q;
  assign remainder_o = rem_q;

endmodule

// ==== muldiv/seq_mul.sv ====
`timescale 1ns/100ps

module seq_mul import rv32m_pkg::*; (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  logic              clear_i,
  input  logic              start_i,
  input  logic [XLEN-1:0]   op_a_i,
  input  logic [XLEN-1:0]   op_b_i,
  output logic [2*XLEN-1:0] product_o,
  output logic              valid_o
);

  logic                  running;
  logic [STEP_CNT_W-1:0] step_cnt;
  logic                  last_step;
  logic                  load;
  logic                  step;
  logic [2*XLEN-1:0]     mcand;   // multiplicand, moves left each step
  logic [XLEN-1:0]       mplier;  // multiplier, moves right each step
  logic [2*XLEN-1:0]     acc;

  assign last_step = (step_cnt == STEP_CNT_W'(MULDIV_STEPS));
  assign load      = start_i && !running;
  assign step      = running && !last_step;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i || clear_i) begin
      running  <= 1'b0;
      step_cnt <= '0;
      valid_o  <= 1'b0;
    end else begin
      valid_o <= 1'b0;
      if (load) begin
        running  <= 1'b1;
        step_cnt <= '0;
      end else if (running) begin
        if (last_step) begin
          running <= 1'b0;
          valid_o <= 1'b1;   // one extra cycle after the final add
        end else begin
          step_cnt <= step_cnt + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (load) begin
      acc    <= '0;
      mcand  <= {{XLEN{1'b0}}, op_a_i};
      mplier <= op_b_i;
    end else if (step) begin
      if (mplier[0]) begin
        acc <= acc + mcand;
      end
      mcand  <= mcand << 1;
      mplier <= mplier >> 1;
    end
  end

  // acc stays put once the steps run out
  assign product_o = acc;

endmodule

// ==== rv32m_unit.f ====
common/rv32m_pkg.sv
muldiv/seq_mul.sv
muldiv/seq_div.sv
muldiv/muldiv_ctrl.sv
design/rv32m_unit.sv
test/rv32m_unit_assert.sv
test/rv32m_unit_tb.sv

// ==== test/rv32m_unit_assert.sv ====
`timescale 1ns/100ps

module rv32m_unit_assert (
  input logic clk_i,
  input logic rst_n_i,
  input logic flush_i,
  input logic done_o,
  input logic busy_o,
  input logic mul_start_o,
  input logic div_start_o
);

  // a finished result and a running operation exclude each other
  done_busy_excl: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(done_o && busy_o))
    else $error("done_o and busy_o high together");

  busy_bounded: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $rose(busy_o) |-> ##[1:40] !busy_o)
    else $error("busy_o high for more than 40 cycles");

  // no launch right after a clear
  start_cleared: assert property (@(posedge clk_i)
    (!rst_n_i || flush_i) |=> (!mul_start_o && !div_start_o))
    else $error("start strobe high one cycle after reset or flush");

endmodule

bind muldiv_ctrl rv32m_unit_assert u_assert (
  .clk_i       (clk_i),
  .rst_n_i     (rst_n_i),
  .flush_i     (flush_i),
  .done_o      (done_o),
  .busy_o      (busy_o),
  .mul_start_o (mul_start_o),
  .div_start_o (div_start_o)
);

// ==== test/rv32m_unit_tb.sv ====
`timescale 1ns/100ps

module rv32m_unit_tb import rv32m_pkg::*; ();

  localparam int N_RAND      = 8;
  localparam int NUM_OPS     = (16 + N_RAND) + 3 * N_RAND + 4 * N_RAND + 6 + 2 + 3;
  localparam int CYCLE_LIMIT = NUM_OPS * 50 + 200;

  logic            clk_i;
  logic            rst_n_i;
  muldiv_req_t     req_i;
  logic            start_i;
  logic            ack_i;
  logic            flush_i;
  logic [XLEN-1:0] result_o;
  logic            done_o;
  logic            busy_o;

  int          check_count = 0;
  int          error_count = 0;
  int          cycle_count = 0;
  logic [31:0] rng_state   = 32'h367f911c;

  rv32m_unit DUT (.*);

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  initial begin
    while (cycle_count < CYCLE_LIMIT) begin
      @(posedge clk_i);
      cycle_count++;
    end
    $display("run timed out after %0d cycles", cycle_count);
    $display("Finished with errors");
    $finish;
  end

  function automatic logic [31:0] next_rand();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  // RISC-V M results worked out in 64 bits
  function automatic logic [31:0] model_result(muldiv_op_e op, logic [31:0] a, logic [31:0] b);
    logic signed [63:0] sa;
    logic signed [63:0] sb;
    logic [63:0]        ua;
    logic [63:0]        ub;
    logic [63:0]        r;
    sa = {{32{a[31]}}, a};
    sb = {{32{b[31]}}, b};
    ua = {32'b0, a};
    ub = {32'b0, b};
    r  = '0;
    case (op)
      MUL:    r = sa * sb;
      MULH:   r = (sa * sb) >> 32;
      MULHSU: r = (sa * $signed(ub)) >> 32;
      MULHU:  r = (ua * ub) >> 32;
      DIV:    r = sa / sb;   // overflow wraps to 2^31
      DIVU:   r = ua / ub;
      REM:    r = sa % sb;
      REMU:   r = ua % ub;
    endcase
    if (op[2] && (b == 0)) begin
      r = (op == REM || op == REMU) ? ua : 64'hffffffff;
    end
    return r[31:0];
  endfunction

  task automatic check_value(string what, logic [31:0] actual, logic [31:0] expected);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("[ERROR] %0t: %s got %h expected %h", $time, what, actual, expected);
    end
  endtask

  task automatic issue_request(muldiv_op_e op, logic [31:0] a, logic [31:0] b);
    @(negedge clk_i);
    req_i.op  = op;
    req_i.rs1 = a;
    req_i.rs2 = b;
    start_i   = 1'b1;
    @(negedge clk_i);
    start_i   = 1'b0;
  endtask

  task automatic wait_for_done(output bit ok);
    int n;
    n = 0;
    while (!done_o && n < 100) begin
      @(negedge clk_i);
      n++;
    end
    ok = done_o;
    if (!ok) begin
      error_count++;
      $display("operation never finished: done_o stayed low for %0d cycles", n);
    end
  endtask

  task automatic send_ack();
    ack_i = 1'b1;
    @(negedge clk_i);
    ack_i = 1'b0;
  endtask

  task automatic run_op(input muldiv_op_e op, input logic [31:0] a, input logic [31:0] b,
                        output logic [31:0] res, output bit ok);
    issue_request(op, a, b);
    wait_for_done(ok);
    res = result_o;
    send_ack();
  endtask

  task automatic check_op(muldiv_op_e op, logic [31:0] a, logic [31:0] b);
    logic [31:0] res;
    bit          ok;
    run_op(op, a, b, res, ok);
    if (ok) check_value($sformatf("%s %h,%h", op.name(), a, b), res, model_result(op, a, b));
  endtask

  task automatic mul_low_word();
    logic [31:0] edges [4];
    int          err0;
    err0  = error_count;
    edges = '{32'h0, 32'h1, 32'hffffffff, 32'h80000000};
    foreach (edges[i]) begin
      foreach (edges[j]) check_op(MUL, edges[i], edges[j]);
    end
    repeat (N_RAND) check_op(MUL, next_rand(), next_rand());
    $display("mul low word done, %0d errors", error_count - err0);
  endtask

  task automatic mul_high_word();
    int err0;
    err0 = error_count;
    for (int k = 1; k <= 3; k++) begin
      repeat (N_RAND) check_op(muldiv_op_e'(k), next_rand(), next_rand());
    end
    $display("mul high word done, %0d errors", error_count - err0);
  endtask

  task automatic divide_random();
    logic signed [31:0] b;
    logic [31:0]        sh;
    int                 err0;
    err0 = error_count;
    for (int k = 4; k <= 7; k++) begin
      repeat (N_RAND) begin
        sh = next_rand();
        b  = next_rand();
        check_op(muldiv_op_e'(k), next_rand(), b >>> sh[4:0]);   // wide spread of quotients
      end
    end
    $display("divide random done, %0d errors", error_count - err0);
  endtask

  task automatic divide_special();
    logic [31:0] a;
    logic [31:0] res;
    bit          ok;
    int          err0;
    err0 = error_count;
    a    = next_rand();
    for (int k = 4; k <= 7; k++) begin
      run_op(muldiv_op_e'(k), a, 32'h0, res, ok);
      if (ok) check_value("divide by zero", res, (k < 6) ? 32'hffffffff : a);
    end
    run_op(DIV, 32'h80000000, 32'hffffffff, res, ok);
    if (ok) check_value("DIV overflow", res, 32'h80000000);
    run_op(REM, 32'h80000000, 32'hffffffff, res, ok);
    if (ok) check_value("REM overflow", res, 32'h0);
    $display("divide special cases done, %0d errors", error_count - err0);
  endtask

  task automatic hold_and_ack();
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] held;
    bit          ok;
    int          err0;
    err0 = error_count;
    a    = next_rand();
    b    = next_rand();
    issue_request(DIV, a, b);
    repeat (5) @(negedge clk_i);
    check_value("busy_o before second start", busy_o, 32'd1);
    issue_request(MUL, ~a, b ^ 32'h5a5a5a5a);   // must be dropped
    wait_for_done(ok);
    held = result_o;
    check_value("result after ignored start", held, model_result(DIV, a, b));
    repeat (20) begin
      @(negedge clk_i);
      check_value("done_o while waiting for ack", done_o, 32'd1);
      check_value("result_o while waiting for ack", result_o, held);
    end
    send_ack();
    check_value("done_o after ack", done_o, 32'd0);
    $display("hold and ack done, %0d errors", error_count - err0);
  endtask

  task automatic flush_midway();
    int err0;
    err0 = error_count;
    issue_request(DIVU, next_rand(), next_rand() | 32'h1);
    repeat (10) @(negedge clk_i);
    flush_i = 1'b1;
    @(negedge clk_i);
    flush_i = 1'b0;
    check_value("busy_o after flush", busy_o, 32'd0);
    check_value("done_o after flush", done_o, 32'd0);
    repeat (40) @(negedge clk_i);
    check_value("done_o long after flush", done_o, 32'd0);
    check_op(MULHSU, next_rand(), next_rand());
    check_op(REM, next_rand(), next_rand());
    $display("flush midway done, %0d errors", error_count - err0);
  endtask

  initial begin
    rst_n_i = 1'b0;
    req_i   = '0;
    start_i = 1'b0;
    ack_i   = 1'b0;
    flush_i = 1'b0;
    repeat (4) @(negedge clk_i);
    rst_n_i = 1'b1;
    mul_low_word();
    mul_high_word();
    divide_random();
    divide_special();
    hold_and_ack();
    flush_midway();
    $display("%0d checks, %0d errors, %0d cycles", check_count, error_count, cycle_count);
    if (error_count == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule
